//--- Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FILE_LIST ?= list.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "result: failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "result: no verdict in log"; exit 1; fi
	@echo "result: passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
+incdir+tests
logic/ex_pkg.sv
logic/int_alu.sv
logic/multiplier.sv
logic/divider.sv
logic/ex_control.sv
logic/ex_stage.sv
tests/tb_ex_stage.sv

//--- logic/divider.sv
/*
 * Iterative restoring divider for DIV, DIVU, REM and REMU.
 * Works on magnitudes for DIV_STEPS cycles, applies signs at the
 * end and flags the result with a one-cycle ready pulse.
 */
module divider (
    input  logic           clk,
    input  logic           reset,
    input  ex_pkg::data_t  op_a,
    input  ex_pkg::data_t  op_b,
    input  logic           div_start,
    input  logic           div_signed,
    output ex_pkg::data_t  quotient,
    output ex_pkg::data_t  remainder,
    output logic           div_ready
);

    logic                                     busy;
    logic [$clog2(ex_pkg::DIV_STEPS)-1:0]     step_cnt;
    logic                                     a_neg;
    logic                                     b_neg;
    ex_pkg::data_t                            a_mag;
    ex_pkg::data_t                            b_mag;
    ex_pkg::data_t                            quo_q;
    ex_pkg::data_t                            rem_q;
    ex_pkg::data_t                            divisor_q;
    ex_pkg::data_t                            dividend_q;
    logic                                     neg_quo;
    logic                                     neg_rem;
    logic                                     by_zero;
    logic [ex_pkg::DATA_WIDTH:0]              shifted;
    logic [ex_pkg::DATA_WIDTH:0]              diff;

    assign a_neg = div_signed && op_a[ex_pkg::DATA_WIDTH-1];
    assign b_neg = div_signed && op_b[ex_pkg::DATA_WIDTH-1];
    assign a_mag = a_neg ? -op_a : op_a;
    assign b_mag = b_neg ? -op_b : op_b;

    // trial subtract, top bit set means the divisor did not fit
    assign shifted = {rem_q, quo_q[ex_pkg::DATA_WIDTH-1]};
    assign diff    = shifted - {1'b0, divisor_q};

    // idle, busy or ready; ready lasts one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            div_ready <= 1'b0;
            step_cnt  <= '0;
        end else if (div_start) begin
            busy     <= 1'b1;
            step_cnt <= $bits(step_cnt)'(ex_pkg::DIV_STEPS - 1);
        end else if (busy) begin
            if (step_cnt == '0) begin
                busy      <= 1'b0;
                div_ready <= 1'b1;
            end
            step_cnt <= step_cnt - 1'b1;
        end else begin
            div_ready <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            quo_q      <= a_mag;
            rem_q      <= '0;
            divisor_q  <= b_mag;
            dividend_q <= op_a;
            neg_quo    <= a_neg ^ b_neg;
            neg_rem    <= a_neg;
            by_zero    <= (op_b == '0);
        end else if (busy) begin
            rem_q <= diff[ex_pkg::DATA_WIDTH] ? shifted[ex_pkg::DATA_WIDTH-1:0]
                                              : diff[ex_pkg::DATA_WIDTH-1:0];
            quo_q <= {quo_q[ex_pkg::DATA_WIDTH-2:0], ~diff[ex_pkg::DATA_WIDTH]};
        end
    end

    // min / -1 needs no special case: magnitude 2^31 stays 0x80000000
    assign quotient  = by_zero ? '1 : (neg_quo ? -quo_q : quo_q);
    assign remainder = by_zero ? dividend_q : (neg_rem ? -rem_q : rem_q);

endmodule

//--- logic/ex_control.sv
/*
 * Execute stage control.
 * Selects operands, decodes the operation into a unit and its
 * sub-operation, starts divisions and raises the stall request
 * until the divide result is ready, then picks the final result.
 */
module ex_control (
    input  logic             clk,
    input  logic             reset,
    input  logic             sel_pc,
    input  logic             sel_imm,
    input  ex_pkg::data_t    rs1_data,
    input  ex_pkg::data_t    rs2_data,
    input  ex_pkg::data_t    pc,
    input  ex_pkg::data_t    imm,
    input  ex_pkg::alu_op_t  alu_op,
    input  ex_pkg::data_t    alu_value,
    input  ex_pkg::data_t    mul_value,
    input  ex_pkg::data_t    quotient,
    input  ex_pkg::data_t    remainder,
    input  logic             div_ready,
    output ex_pkg::data_t    op_a,
    output ex_pkg::data_t    op_b,
    output ex_pkg::alu_op_t  alu_func,
    output logic             mul_high,
    output logic             mul_a_signed,
    output logic             mul_b_signed,
    output logic             div_start,
    output logic             div_signed,
    output ex_pkg::data_t    alu_result,
    output logic             stall_req
);

    logic is_mul;
    logic is_div;
    logic is_rem;
    logic div_busy;

    // operand muxes
    assign op_a = sel_pc  ? pc  : rs1_data;
    assign op_b = sel_imm ? imm : rs2_data;

    // unit decode
    assign is_mul = alu_op inside {ex_pkg::OP_MUL, ex_pkg::OP_MULH,
                                   ex_pkg::OP_MULHSU, ex_pkg::OP_MULHU};
    assign is_div = alu_op inside {ex_pkg::OP_DIV, ex_pkg::OP_DIVU,
                                   ex_pkg::OP_REM, ex_pkg::OP_REMU};
    assign is_rem = alu_op inside {ex_pkg::OP_REM, ex_pkg::OP_REMU};

    // non-ALU codes fall to the ALU default and give zero there
    assign alu_func = alu_op;

    // multiplier sub-operation
    assign mul_high     = (alu_op != ex_pkg::OP_MUL);
    assign mul_a_signed = (alu_op == ex_pkg::OP_MULH) || (alu_op == ex_pkg::OP_MULHSU);
    assign mul_b_signed = (alu_op == ex_pkg::OP_MULH);

    assign div_signed = (alu_op == ex_pkg::OP_DIV) || (alu_op == ex_pkg::OP_REM);

    // set by the start pulse, cleared one edge after the ready cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            div_busy <= 1'b0;
        end else if (div_start) begin
            div_busy <= 1'b1;
        end else if (div_ready) begin
            div_busy <= 1'b0;
        end
    end

    // one start per division
    assign div_start = is_div && !div_busy;

    // hold the pipeline until the quotient or remainder is there
    assign stall_req = is_div && !div_ready;

    always_comb begin
        if (is_div) begin
            alu_result = is_rem ? remainder : quotient;
        end else if (is_mul) begin
            alu_result = mul_value;
        end else begin
            alu_result = alu_value;
        end
    end

endmodule

//--- logic/ex_pkg.sv
/*
 * Shared definitions for the execute stage.
 * Data and operation-code widths, the data word type and the
 * operation encoding used by the control and datapath blocks.
 */
package ex_pkg;

    localparam int unsigned DATA_WIDTH   = 32;
    localparam int unsigned SHAMT_WIDTH  = 5;
    localparam int unsigned ALU_OP_WIDTH = 5;
    // one quotient bit per iteration
    localparam int unsigned DIV_STEPS    = DATA_WIDTH;

    typedef logic [DATA_WIDTH-1:0] data_t;

    // integer, multiply and divide codes share one space
    typedef enum logic [ALU_OP_WIDTH-1:0] {
        OP_ADD    = 5'd0,
        OP_SUB    = 5'd1,
        OP_SLL    = 5'd2,
        OP_SLT    = 5'd3,
        OP_SLTU   = 5'd4,
        OP_XOR    = 5'd5,
        OP_SRL    = 5'd6,
        OP_SRA    = 5'd7,
        OP_OR     = 5'd8,
        OP_AND    = 5'd9,
        // pass operand B through
        OP_LUI    = 5'd10,
        OP_MUL    = 5'd11,
        OP_MULH   = 5'd12,
        OP_MULHSU = 5'd13,
        OP_MULHU  = 5'd14,
        OP_DIV    = 5'd15,
        OP_DIVU   = 5'd16,
        OP_REM    = 5'd17,
        OP_REMU   = 5'd18
    } alu_op_t;

endpackage

//--- logic/ex_stage.sv
/*
 * Execute stage top level.
 * Connects the control block to the integer ALU, the multiplier
 * and the iterative divider.
 */
module ex_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             sel_pc,
    input  logic             sel_imm,
    input  ex_pkg::data_t    rs1_data,
    input  ex_pkg::data_t    rs2_data,
    input  ex_pkg::data_t    pc,
    input  ex_pkg::data_t    imm,
    input  ex_pkg::alu_op_t  alu_op,
    output ex_pkg::data_t    alu_result,
    output logic             stall_req
);

    ex_pkg::data_t    op_a;
    ex_pkg::data_t    op_b;
    ex_pkg::alu_op_t  alu_func;
    ex_pkg::data_t    alu_value;
    ex_pkg::data_t    mul_value;
    ex_pkg::data_t    quotient;
    ex_pkg::data_t    remainder;
    logic             mul_high;
    logic             mul_a_signed;
    logic             mul_b_signed;
    logic             div_start;
    logic             div_signed;
    logic             div_ready;

    ex_control u_control (
        .clk          (clk),
        .reset        (reset),
        .sel_pc       (sel_pc),
        .sel_imm      (sel_imm),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .pc           (pc),
        .imm          (imm),
        .alu_op       (alu_op),
        .alu_value    (alu_value),
        .mul_value    (mul_value),
        .quotient     (quotient),
        .remainder    (remainder),
        .div_ready    (div_ready),
        .op_a         (op_a),
        .op_b         (op_b),
        .alu_func     (alu_func),
        .mul_high     (mul_high),
        .mul_a_signed (mul_a_signed),
        .mul_b_signed (mul_b_signed),
        .div_start    (div_start),
        .div_signed   (div_signed),
        .alu_result   (alu_result),
        .stall_req    (stall_req)
    );

    int_alu u_alu (
        .op_a      (op_a),
        .op_b      (op_b),
        .alu_func  (alu_func),
        .alu_value (alu_value)
    );

    multiplier u_mul (
        .op_a         (op_a),
        .op_b         (op_b),
        .mul_high     (mul_high),
        .mul_a_signed (mul_a_signed),
        .mul_b_signed (mul_b_signed),
        .mul_value    (mul_value)
    );

    divider u_div (
        .clk        (clk),
        .reset      (reset),
        .op_a       (op_a),
        .op_b       (op_b),
        .div_start  (div_start),
        .div_signed (div_signed),
        .quotient   (quotient),
        .remainder  (remainder),
        .div_ready  (div_ready)
    );

endmodule

//--- logic/int_alu.sv
/*
 * Single-cycle integer ALU.
 * Add, subtract, shifts, signed and unsigned compare, bitwise
 * logic and pass-B; any other code gives zero.
 */
module int_alu (
    input  ex_pkg::data_t    op_a,
    input  ex_pkg::data_t    op_b,
    input  ex_pkg::alu_op_t  alu_func,
    output ex_pkg::data_t    alu_value
);

    logic [ex_pkg::SHAMT_WIDTH-1:0] shamt;
    logic                           lt_signed;
    logic                           lt_unsigned;

    // only the low bits of B count as shift amount
    assign shamt = op_b[ex_pkg::SHAMT_WIDTH-1:0];

    assign lt_signed   = ($signed(op_a) < $signed(op_b));
    assign lt_unsigned = (op_a < op_b);

    always_comb begin
        case (alu_func)
            ex_pkg::OP_ADD: begin
                alu_value = op_a + op_b;
            end
            ex_pkg::OP_SUB: begin
                alu_value = op_a - op_b;
            end
            ex_pkg::OP_SLL: begin
                alu_value = op_a << shamt;
            end
            ex_pkg::OP_SLT: begin
                alu_value = {{(ex_pkg::DATA_WIDTH-1){1'b0}}, lt_signed};
            end
            ex_pkg::OP_SLTU: begin
                alu_value = {{(ex_pkg::DATA_WIDTH-1){1'b0}}, lt_unsigned};
            end
            ex_pkg::OP_XOR: begin
                alu_value = op_a ^ op_b;
            end
            ex_pkg::OP_SRL: begin
                alu_value = op_a >> shamt;
            end
            ex_pkg::OP_SRA: begin
                // arithmetic shift fills with the sign bit
                alu_value = ex_pkg::data_t'($signed(op_a) >>> shamt);
            end
            ex_pkg::OP_OR: begin
                alu_value = op_a | op_b;
            end
            ex_pkg::OP_AND: begin
                alu_value = op_a & op_b;
            end
            ex_pkg::OP_LUI: begin
                alu_value = op_b;
            end
            default: begin
                alu_value = '0;
            end
        endcase
    end

endmodule

//--- logic/multiplier.sv
/*
 * 32x32 multiplier for the RV32M multiply family.
 * Each operand is extended by one bit per its signedness, so one
 * signed product covers MUL, MULH, MULHSU and MULHU.
 */
module multiplier (
    input  ex_pkg::data_t  op_a,
    input  ex_pkg::data_t  op_b,
    input  logic           mul_high,
    input  logic           mul_a_signed,
    input  logic           mul_b_signed,
    output ex_pkg::data_t  mul_value
);

    logic signed [ex_pkg::DATA_WIDTH:0]       a_ext;
    logic signed [ex_pkg::DATA_WIDTH:0]       b_ext;
    logic signed [2*ex_pkg::DATA_WIDTH+1:0]   product;

    // zero extension makes an operand read as unsigned
    assign a_ext = {mul_a_signed & op_a[ex_pkg::DATA_WIDTH-1], op_a};
    assign b_ext = {mul_b_signed & op_b[ex_pkg::DATA_WIDTH-1], op_b};

    assign product = a_ext * b_ext;

    // high word for the MULH variants
    assign mul_value = mul_high ? product[2*ex_pkg::DATA_WIDTH-1:ex_pkg::DATA_WIDTH]
                                : product[ex_pkg::DATA_WIDTH-1:0];

endmodule

//--- tests/ex_vectors.svh
/*
 * Vector table for the execute stage testbench.
 * Stimulus for each entry and the alu_result it must give.
 */
`ifndef EX_VECTORS_SVH
`define EX_VECTORS_SVH

typedef struct packed {
    logic            sel_pc;
    logic            sel_imm;
    ex_pkg::data_t   rs1_data;
    ex_pkg::data_t   rs2_data;
    ex_pkg::data_t   pc;
    ex_pkg::data_t   imm;
    ex_pkg::alu_op_t alu_op;
    ex_pkg::data_t   expected;
} vector_t;

localparam int NUM_VECTORS = 33;

// sel_pc, sel_imm, rs1_data, rs2_data, pc, imm, alu_op, expected alu_result
localparam vector_t VECTORS [NUM_VECTORS] = '{
    '{1'b0, 1'b0, 32'h5, 32'h7, 32'h0, 32'h0, ex_pkg::OP_ADD, 32'h0000000c},
    '{1'b0, 1'b0, 32'hffffffff, 32'h1, 32'h0, 32'h0, ex_pkg::OP_ADD, 32'h00000000},
    '{1'b0, 1'b0, 32'h3, 32'h5, 32'h0, 32'h0, ex_pkg::OP_SUB, 32'hfffffffe},
    // shift amounts use only the low 5 bits of B
    '{1'b0, 1'b0, 32'h1, 32'h00000024, 32'h0, 32'h0, ex_pkg::OP_SLL, 32'h00000010},
    '{1'b0, 1'b0, 32'h80000000, 32'hffffffe4, 32'h0, 32'h0, ex_pkg::OP_SRL, 32'h08000000},
    '{1'b0, 1'b0, 32'h80000000, 32'h4, 32'h0, 32'h0, ex_pkg::OP_SRA, 32'hf8000000},
    '{1'b0, 1'b0, 32'h40000000, 32'h4, 32'h0, 32'h0, ex_pkg::OP_SRA, 32'h04000000},
    '{1'b0, 1'b0, 32'hfffffffe, 32'h1, 32'h0, 32'h0, ex_pkg::OP_SLT, 32'h00000001},
    '{1'b0, 1'b0, 32'hfffffffe, 32'h1, 32'h0, 32'h0, ex_pkg::OP_SLTU, 32'h00000000},
    '{1'b0, 1'b0, 32'hff00ff00, 32'h0f0f0f0f, 32'h0, 32'h0, ex_pkg::OP_XOR, 32'hf00ff00f},
    '{1'b0, 1'b0, 32'hff00ff00, 32'h0f0f0f0f, 32'h0, 32'h0, ex_pkg::OP_OR, 32'hff0fff0f},
    '{1'b0, 1'b0, 32'hff00ff00, 32'h0f0f0f0f, 32'h0, 32'h0, ex_pkg::OP_AND, 32'h0f000f00},
    '{1'b0, 1'b1, 32'h0, 32'hdeadbeef, 32'h0, 32'h12345000, ex_pkg::OP_LUI, 32'h12345000},
    '{1'b1, 1'b1, 32'h1, 32'h2, 32'h00001000, 32'h00000ffc, ex_pkg::OP_ADD, 32'h00001ffc},
    '{1'b0, 1'b0, 32'h11111111, 32'h22222222, 32'h0, 32'h0, ex_pkg::alu_op_t'(5'd31), 32'h0},
    '{1'b0, 1'b0, 32'h7, 32'hfffffffd, 32'h0, 32'h0, ex_pkg::OP_MUL, 32'hffffffeb},
    '{1'b0, 1'b0, 32'hffffffff, 32'hffffffff, 32'h0, 32'h0, ex_pkg::OP_MUL, 32'h00000001},
    '{1'b0, 1'b0, 32'h80000000, 32'h80000000, 32'h0, 32'h0, ex_pkg::OP_MULH, 32'h40000000},
    '{1'b0, 1'b0, 32'hfffffffd, 32'h7, 32'h0, 32'h0, ex_pkg::OP_MULH, 32'hffffffff},
    '{1'b0, 1'b0, 32'hffffffff, 32'hffffffff, 32'h0, 32'h0, ex_pkg::OP_MULHSU, 32'hffffffff},
    '{1'b0, 1'b0, 32'h2, 32'hffffffff, 32'h0, 32'h0, ex_pkg::OP_MULHSU, 32'h00000001},
    '{1'b0, 1'b0, 32'hffffffff, 32'hffffffff, 32'h0, 32'h0, ex_pkg::OP_MULHU, 32'hfffffffe},
    // divides, several of them back to back
    '{1'b0, 1'b0, 32'hfffffff9, 32'h2, 32'h0, 32'h0, ex_pkg::OP_DIV, 32'hfffffffd},
    '{1'b0, 1'b0, 32'hfffffff9, 32'h2, 32'h0, 32'h0, ex_pkg::OP_REM, 32'hffffffff},
    '{1'b0, 1'b0, 32'hfffffff9, 32'h2, 32'h0, 32'h0, ex_pkg::OP_DIVU, 32'h7ffffffc},
    '{1'b0, 1'b0, 32'hfffffff9, 32'h2, 32'h0, 32'h0, ex_pkg::OP_REMU, 32'h00000001},
    '{1'b0, 1'b0, 32'h7, 32'hfffffffe, 32'h0, 32'h0, ex_pkg::OP_DIV, 32'hfffffffd},
    '{1'b0, 1'b0, 32'h7, 32'hfffffffe, 32'h0, 32'h0, ex_pkg::OP_REM, 32'h00000001},
    '{1'b0, 1'b0, 32'h5, 32'h0, 32'h0, 32'h0, ex_pkg::OP_DIV, 32'hffffffff},
    '{1'b0, 1'b0, 32'hfffffff9, 32'h0, 32'h0, 32'h0, ex_pkg::OP_REM, 32'hfffffff9},
    '{1'b0, 1'b0, 32'h80000000, 32'hffffffff, 32'h0, 32'h0, ex_pkg::OP_DIV, 32'h80000000},
    '{1'b0, 1'b0, 32'h80000000, 32'hffffffff, 32'h0, 32'h0, ex_pkg::OP_REM, 32'h00000000},
    '{1'b0, 1'b0, 32'h1, 32'h2, 32'h0, 32'h0, ex_pkg::OP_ADD, 32'h00000003}
};

`endif

//--- tests/tb_ex_stage.sv
/*
 * Testbench for the execute stage.
 * Walks the vector table, waits out divides on the stall request
 * and compares every result with the table.
 */
module tb_ex_stage;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    // divide latency plus some margin
    localparam int DIV_TIMEOUT  = int'(ex_pkg::DIV_STEPS) + 8;

    `include "ex_vectors.svh"

    logic             clk;
    logic             reset;
    logic             sel_pc;
    logic             sel_imm;
    ex_pkg::data_t    rs1_data;
    ex_pkg::data_t    rs2_data;
    ex_pkg::data_t    pc;
    ex_pkg::data_t    imm;
    ex_pkg::alu_op_t  alu_op;
    ex_pkg::data_t    alu_result;
    logic             stall_req;
    int               error_count;
    int               check_count;

    ex_stage u_dut (
        .clk        (clk),
        .reset      (reset),
        .sel_pc     (sel_pc),
        .sel_imm    (sel_imm),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .pc         (pc),
        .imm        (imm),
        .alu_op     (alu_op),
        .alu_result (alu_result),
        .stall_req  (stall_req)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input int entry,
                               input ex_pkg::data_t actual, input ex_pkg::data_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s (entry %0d): got 0x%08h, expected 0x%08h",
                     name, entry, actual, expected);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR: %s", msg);
    endtask

    function automatic logic is_divide(input ex_pkg::alu_op_t op);
        return op inside {ex_pkg::OP_DIV, ex_pkg::OP_DIVU, ex_pkg::OP_REM, ex_pkg::OP_REMU};
    endfunction

    // starts and ends on a falling edge
    task automatic run_entry(input int idx);
        vector_t vec;
        int      waited;
        vec      = VECTORS[idx];
        sel_pc   = vec.sel_pc;
        sel_imm  = vec.sel_imm;
        rs1_data = vec.rs1_data;
        rs2_data = vec.rs2_data;
        pc       = vec.pc;
        imm      = vec.imm;
        alu_op   = vec.alu_op;
        check_count++;
        if (!is_divide(vec.alu_op)) begin
            // non-divide results are sampled within the same cycle
            #(CLK_PERIOD / 4);
            if (stall_req) begin
                report_error($sformatf("entry %0d raised stall_req without a divide", idx));
            end
            check_value("alu_result", idx, alu_result, vec.expected);
            @(negedge clk);
        end else begin
            @(negedge clk);
            if (!stall_req) begin
                report_error($sformatf("entry %0d is a divide but stall_req stayed low", idx));
            end
            waited = 0;
            while (stall_req && waited < DIV_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (stall_req) begin
                report_error($sformatf("entry %0d: stall_req still high after %0d cycles",
                                       idx, waited));
            end else begin
                check_value("alu_result", idx, alu_result, vec.expected);
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        sel_pc      = 1'b0;
        sel_imm     = 1'b0;
        rs1_data    = '0;
        rs2_data    = '0;
        pc          = '0;
        imm         = '0;
        alu_op      = ex_pkg::OP_ADD;
        error_count = 0;
        check_count = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_count++;
        if (stall_req) begin
            report_error("stall_req is high after reset with an add presented");
        end
        for (int i = 0; i < NUM_VECTORS; i++) begin
            run_entry(i);
        end
        $display("tb_ex_stage: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
